/* filelist.f */
+incdir+sim
src/dbg_pkg.sv
src/pipe_tracker.sv
src/reg_bank.sv
src/debug_unit.sv
src/dbg_subsystem.sv
sim/tb_dbg_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_dbg_subsystem
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

# pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_dbg_tasks.svh */
//////////////////////////////
// host and core drive tasks, typed compare tasks
// and the xorshift data source for the debug testbench
// included inside the testbench module, uses its signals
//////////////////////////////

`ifndef TB_DBG_TASKS_SVH
`define TB_DBG_TASKS_SVH

// xorshift32 step for write data
function automatic dbg_data_t next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

//////////////////////////////
// address map helpers
//////////////////////////////

function automatic dbg_addr_t gpr_addr(input gpr_idx_t idx);
  return {GPR_PREFIX, 5'b0, idx};
endfunction

// upper bits zero, outside both the GPR and the debug group
function automatic dbg_addr_t spr_addr(input spr_idx_t idx);
  return {13'b0, idx};
endfunction

function automatic dbg_addr_t dbg_reg_addr(input logic [10:0] ofs);
  return {DBG_REG_PREFIX, ofs};
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_data(input dbg_data_t got, input dbg_data_t exp, input string what);
  if (got !== exp)
  begin
    $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_dsr(input dsr_t got, input dsr_t exp, input string what);
  if (got !== exp)
  begin
    $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp)
  begin
    $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    stop_on_failure();
  end
endtask

//////////////////////////////
// core side
//////////////////////////////

// n back to back issues, trap flag on issue number trap_at
task automatic issue_n(input int n, input int trap_at);
  for (int i = 0; i < n; i++)
  begin
    @(negedge clk);
    issue      = 1'b1;
    issue_trap = (i == trap_at);
  end
  @(negedge clk);
  issue      = 1'b0;
  issue_trap = 1'b0;
endtask

// polls from a falling edge, samples mid low phase
task automatic wait_stalled(input logic level);
  int waited;
  waited = 0;
  #(CLK_PERIOD / 4);
  while (core_stalled !== level)
  begin
    if (waited == WAIT_MAX)
    begin
      $display("core stall did not reach %b within %0d cycles", level, WAIT_MAX);
      stop_on_failure();
    end
    waited++;
    @(negedge clk);
    #(CLK_PERIOD / 4);
  end
endtask

task automatic do_stall();
  @(negedge clk);
  dbg_stall = 1'b1;
  wait_stalled(1'b1);
endtask

task automatic do_release();
  @(negedge clk);
  dbg_stall = 1'b0;
  wait_stalled(1'b0);
endtask

// host answers a bp pulse by holding the stall
task automatic wait_break();
  int waited;
  waited = 0;
  #(CLK_PERIOD / 4);
  while (dbg_bp !== 1'b1)
  begin
    if (waited == WAIT_MAX)
    begin
      $display("no breakpoint pulse within %0d cycles", WAIT_MAX);
      stop_on_failure();
    end
    waited++;
    @(negedge clk);
    #(CLK_PERIOD / 4);
  end
  @(negedge clk);
  dbg_stall = 1'b1;
  wait_stalled(1'b1);
endtask

//////////////////////////////
// host side
//////////////////////////////

// strobe held until ack, access lands on the edge after the ack sample
task automatic host_access(input logic we, input dbg_addr_t addr, input dbg_data_t wdata,
                           output dbg_data_t rdata);
  int waited;
  waited = 0;
  @(negedge clk);
  dbg_strobe = 1'b1;
  dbg_we     = we;
  dbg_addr   = addr;
  dbg_wdata  = wdata;
  #(CLK_PERIOD / 4);
  while (dbg_ack !== 1'b1)
  begin
    if (waited == WAIT_MAX)
    begin
      $display("no ack for address 0x%04h within %0d cycles", addr, WAIT_MAX);
      stop_on_failure();
    end
    waited++;
    @(negedge clk);
    #(CLK_PERIOD / 4);
  end
  rdata = dbg_rdata;
  @(negedge clk);
  dbg_strobe = 1'b0;
  dbg_we     = 1'b0;
endtask

task automatic host_write(input dbg_addr_t addr, input dbg_data_t data);
  dbg_data_t unused;
  host_access(1'b1, addr, data, unused);
endtask

task automatic host_read(input dbg_addr_t addr, output dbg_data_t data);
  host_access(1'b0, addr, '0, data);
endtask

`endif

/* sim/tb_dbg_subsystem.sv */
//////////////////////////////
// directed testbench for the debug subsystem
// host stall, register access, trap and single-step breaks
// stimulus on the falling edge and outputs sampled mid low phase
//////////////////////////////

`timescale 1ns/1ps

module tb_dbg_subsystem
  import dbg_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 5;
  localparam int WAIT_MAX      = 40;
  localparam int NO_ACK_CYCLES = 10;

  // cycle budget per test summed into the watchdog limit
  localparam int T_GPR   = 60;
  localparam int T_SPR   = 80;
  localparam int T_DREG  = 40;
  localparam int T_TRAP  = 90;
  localparam int T_STEP  = 70;
  localparam int T_NOACC = 40;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + T_GPR + T_SPR + T_DREG + T_TRAP
                                   + T_STEP + T_NOACC;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      dbg_stall;
  logic      dbg_strobe;
  logic      dbg_we;
  dbg_addr_t dbg_addr;
  dbg_data_t dbg_wdata;
  logic      dbg_bp;
  logic      dbg_ack;
  dbg_data_t dbg_rdata;
  logic      issue;
  logic      issue_trap;
  logic      core_stalled;
  dsr_t      dbg_dsr;

  // reference state kept from the access rules
  dbg_data_t exp_gpr [32];
  int        exp_retired = 0;
  int        bp_count    = 0;
  dbg_data_t rng_state   = 32'd81;

  always #(CLK_PERIOD / 2) clk = ~clk;

  dbg_subsystem u_dbg_subsystem (
    .clk            (clk),
    .rst_n          (rst_n),
    .dbg_stall_i    (dbg_stall),
    .dbg_strobe_i   (dbg_strobe),
    .dbg_we_i       (dbg_we),
    .dbg_addr_i     (dbg_addr),
    .dbg_wdata_i    (dbg_wdata),
    .dbg_bp_o       (dbg_bp),
    .dbg_ack_o      (dbg_ack),
    .dbg_rdata_o    (dbg_rdata),
    .issue_i        (issue),
    .issue_trap_i   (issue_trap),
    .core_stalled_o (core_stalled),
    .dbg_dsr_o      (dbg_dsr)
  );

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  `include "tb_dbg_tasks.svh"

  // counts bp pulses with one sample per cycle
  always
  begin
    @(negedge clk);
    #(CLK_PERIOD / 4);
    if (rst_n === 1'b1 && dbg_bp === 1'b1)
      bp_count++;
  end

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_gpr_access();
    gpr_idx_t  idx [4];
    dbg_data_t rd;
    int        bp_before;
    idx       = '{5'd1, 5'd7, 5'd19, 5'd31};
    bp_before = bp_count;
    issue_n(3, -1);
    exp_retired += 3;
    do_stall();
    check_bit(logic'(bp_count == bp_before), 1'b1, "no bp pulse on host stall");
    for (int i = 0; i < 4; i++)
    begin
      exp_gpr[idx[i]] = next_rand();
      host_write(gpr_addr(idx[i]), exp_gpr[idx[i]]);
    end
    for (int i = 0; i < 4; i++)
    begin
      host_read(gpr_addr(idx[i]), rd);
      check_data(rd, exp_gpr[idx[i]], $sformatf("GPR %0d", idx[i]));
    end
  endtask

  task automatic test_spr_counter();
    dbg_data_t rd;
    dbg_data_t val;
    host_read(spr_addr(SPR_RETIRE_IDX), rd);
    check_data(rd, dbg_data_t'(exp_retired), "retire counter after stall");
    val = next_rand();
    host_write(spr_addr(3'd5), val);
    host_read(spr_addr(3'd5), rd);
    check_data(rd, val, "SPR 5");
    // counter keeps running across a release
    do_release();
    issue_n(4, -1);
    exp_retired += 4;
    do_stall();
    host_read(spr_addr(SPR_RETIRE_IDX), rd);
    check_data(rd, dbg_data_t'(exp_retired), "retire counter after 4 issues");
    // counting goes on from a host preset
    exp_retired = 32'h100;
    host_write(spr_addr(SPR_RETIRE_IDX), dbg_data_t'(exp_retired));
    do_release();
    issue_n(2, -1);
    exp_retired += 2;
    do_stall();
    host_read(spr_addr(SPR_RETIRE_IDX), rd);
    check_data(rd, dbg_data_t'(exp_retired), "retire counter after preset");
  endtask

  task automatic test_debug_regs();
    dbg_data_t rd;
    dbg_data_t wr;
    wr = '0;
    wr[DSR_LSB +: 2] = 2'b10;
    host_write(dbg_reg_addr(ADDR_DSR), wr);
    host_read(dbg_reg_addr(ADDR_DSR), rd);
    check_dsr(rd[DSR_LSB +: 2], 2'b10, "DSR read");
    check_dsr(dbg_dsr, 2'b10, "DSR core output");
    wr = '0;
    wr[DMR1_ST_BIT] = 1'b1;
    host_write(dbg_reg_addr(ADDR_DMR1), wr);
    host_read(dbg_reg_addr(ADDR_DMR1), rd);
    check_bit(rd[DMR1_ST_BIT], 1'b1, "DMR1 single step");
    // back to free running for the trap test
    host_write(dbg_reg_addr(ADDR_DMR1), '0);
    host_read(dbg_reg_addr(ADDR_DMR1), rd);
    check_bit(rd[DMR1_ST_BIT], 1'b0, "DMR1 single step cleared");
    wr = '0;
    wr[DMR2_EN_BIT] = 1'b1;
    host_write(dbg_reg_addr(ADDR_DMR2), wr);
    host_read(dbg_reg_addr(ADDR_DMR2), rd);
    check_bit(rd[DMR2_EN_BIT], 1'b1, "DMR2 trap enable");
    check_bit(rd[DMR2_STAT_BIT], 1'b0, "DMR2 status before trap");
  endtask

  task automatic test_trap_break();
    dbg_data_t rd;
    dbg_data_t wr;
    int        bp_before;
    do_release();
    bp_before = bp_count;
    // plain instructions run through with the enable set
    issue_n(2, -1);
    exp_retired += 2;
    repeat (2 * PIPE_DEPTH) @(negedge clk);
    check_bit(core_stalled, 1'b0, "core stall without a trap instruction");
    check_bit(logic'(bp_count == bp_before), 1'b1, "no bp pulse without a trap instruction");
    issue_n(3, 1);
    exp_retired += 3;
    wait_break();
    check_bit(logic'(bp_count == bp_before + 1), 1'b1, "one bp pulse per trap");
    host_read(dbg_reg_addr(ADDR_DMR2), rd);
    check_bit(rd[DMR2_STAT_BIT], 1'b1, "DMR2 status after trap");
    check_bit(rd[DMR2_EN_BIT], 1'b1, "DMR2 enable after trap");
    // rewrite keeps the enable and clears the status
    wr = '0;
    wr[DMR2_EN_BIT] = 1'b1;
    host_write(dbg_reg_addr(ADDR_DMR2), wr);
    host_read(dbg_reg_addr(ADDR_DMR2), rd);
    check_bit(rd[DMR2_STAT_BIT], 1'b0, "DMR2 status after write");
    host_read(spr_addr(SPR_RETIRE_IDX), rd);
    check_data(rd, dbg_data_t'(exp_retired), "retire counter after trap");
    // same trap with the enable off runs through
    host_write(dbg_reg_addr(ADDR_DMR2), '0);
    do_release();
    bp_before = bp_count;
    issue_n(3, 1);
    exp_retired += 3;
    repeat (2 * PIPE_DEPTH) @(negedge clk);
    check_bit(core_stalled, 1'b0, "core stall with trap break disabled");
    check_bit(logic'(bp_count == bp_before), 1'b1, "no bp pulse with trap break disabled");
    do_stall();
  endtask

  task automatic test_single_step();
    dbg_data_t rd;
    dbg_data_t wr;
    int        bp_before;
    wr = '0;
    wr[DMR1_ST_BIT] = 1'b1;
    host_write(dbg_reg_addr(ADDR_DMR1), wr);
    for (int s = 0; s < 3; s++)
    begin
      do_release();
      bp_before = bp_count;
      issue_n(1, -1);
      exp_retired += 1;
      wait_break();
      check_bit(logic'(bp_count == bp_before + 1), 1'b1, "one bp pulse per step");
      host_read(spr_addr(SPR_RETIRE_IDX), rd);
      check_data(rd, dbg_data_t'(exp_retired), $sformatf("retire counter at step %0d", s));
    end
    host_write(dbg_reg_addr(ADDR_DMR1), '0);
  endtask

  task automatic test_no_access();
    dbg_data_t rd;
    dbg_data_t old_val;
    old_val = exp_gpr[7];
    do_release();
    @(negedge clk);
    dbg_strobe = 1'b1;
    dbg_we     = 1'b1;
    dbg_addr   = gpr_addr(5'd7);
    dbg_wdata  = ~old_val;
    repeat (NO_ACK_CYCLES)
    begin
      #(CLK_PERIOD / 4);
      check_bit(dbg_ack, 1'b0, "ack while the core runs");
      @(negedge clk);
    end
    dbg_strobe = 1'b0;
    dbg_we     = 1'b0;
    do_stall();
    host_read(gpr_addr(5'd7), rd);
    check_data(rd, old_val, "GPR 7 after refused write");
  endtask

  //////////////////////////////
  // sequence and watchdog
  //////////////////////////////

  initial
  begin
    rst_n      = 1'b0;
    dbg_stall  = 1'b0;
    dbg_strobe = 1'b0;
    dbg_we     = 1'b0;
    dbg_addr   = '0;
    dbg_wdata  = '0;
    issue      = 1'b0;
    issue_trap = 1'b0;
    // all registers start at zero
    for (int i = 0; i < 32; i++)
      exp_gpr[i] = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    test_gpr_access();
    test_spr_counter();
    test_debug_regs();
    test_trap_break();
    test_single_step();
    test_no_access();
    $display("Test passed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_on_failure();
  end

endmodule

/* src/dbg_subsystem.sv */
//////////////////////////////
// debug subsystem top
// pipeline tracker and register bank side by side,
// joined by the debug unit toward the host port
//////////////////////////////

`timescale 1ns/1ps

module dbg_subsystem
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // host port
  input  logic      dbg_stall_i,
  input  logic      dbg_strobe_i,
  input  logic      dbg_we_i,
  input  dbg_addr_t dbg_addr_i,
  input  dbg_data_t dbg_wdata_i,
  output logic      dbg_bp_o,
  output logic      dbg_ack_o,
  output dbg_data_t dbg_rdata_o,

  // core side
  input  logic      issue_i,
  input  logic      issue_trap_i,
  output logic      core_stalled_o,
  output dsr_t      dbg_dsr_o
);

  // debug unit to tracker
  logic flush_pipe;
  logic stall_core;
  logic st_en;

  // tracker status
  logic pipe_flushed;
  logic trap;
  logic retire;

  // register bank access
  logic      gpr_sel;
  logic      spr_sel;
  logic      rf_we;
  dbg_addr_t rf_addr;
  dbg_data_t rf_wdata;
  dbg_data_t rf_rdata;

  pipe_tracker u_pipe (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_i      (issue_i),
    .issue_trap_i (issue_trap_i),
    .flush_i      (flush_pipe),
    .stall_i      (stall_core),
    .st_en_i      (st_en),
    .retire_o     (retire),
    .trap_o       (trap),
    .flushed_o    (pipe_flushed)
  );

  reg_bank u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .gpr_sel_i (gpr_sel),
    .spr_sel_i (spr_sel),
    .we_i      (rf_we),
    .addr_i    (rf_addr),
    .wdata_i   (rf_wdata),
    .rdata_o   (rf_rdata),
    .retire_i  (retire)
  );

  debug_unit u_dbg (
    .clk            (clk),
    .rst_n          (rst_n),
    .dbg_stall_i    (dbg_stall_i),
    .dbg_bp_o       (dbg_bp_o),
    .dbg_strobe_i   (dbg_strobe_i),
    .dbg_ack_o      (dbg_ack_o),
    .dbg_we_i       (dbg_we_i),
    .dbg_addr_i     (dbg_addr_i),
    .dbg_wdata_i    (dbg_wdata_i),
    .dbg_rdata_o    (dbg_rdata_o),
    .st_en_o        (st_en),
    .dsr_o          (dbg_dsr_o),
    .stall_core_o   (stall_core),
    .flush_pipe_o   (flush_pipe),
    .pipe_flushed_i (pipe_flushed),
    .trap_i         (trap),
    .gpr_sel_o      (gpr_sel),
    .spr_sel_o      (spr_sel),
    .rf_we_o        (rf_we),
    .rf_addr_o      (rf_addr),
    .rf_wdata_o     (rf_wdata),
    .rf_rdata_i     (rf_rdata)
  );

  // core held while the break lasts
  assign core_stalled_o = stall_core;

endmodule

/* src/debug_unit.sv */
//////////////////////////////
// debug controller
// break FSM for host stall, trap and single step,
// DMR1/DMR2/DSR registers and the two-level address decode
// register access is acked only while the core sits in StallCore
//////////////////////////////

`timescale 1ns/1ps

module debug_unit
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // host port
  input  logic      dbg_stall_i,
  output logic      dbg_bp_o,
  input  logic      dbg_strobe_i,
  output logic      dbg_ack_o,
  input  logic      dbg_we_i,
  input  dbg_addr_t dbg_addr_i,
  input  dbg_data_t dbg_wdata_i,
  output dbg_data_t dbg_rdata_o,

  // core control
  output logic      st_en_o,
  output dsr_t      dsr_o,
  output logic      stall_core_o,
  output logic      flush_pipe_o,
  input  logic      pipe_flushed_i,
  input  logic      trap_i,

  // register bank access
  output logic      gpr_sel_o,
  output logic      spr_sel_o,
  output logic      rf_we_o,
  output dbg_addr_t rf_addr_o,
  output dbg_data_t rf_wdata_o,
  input  dbg_data_t rf_rdata_i
);

  // break FSM
  bp_state_e state_q, state_d;

  // debug registers with only the implemented bits
  logic dmr1_st_q;
  logic dmr2_en_q;
  logic dmr2_stat_q;
  dsr_t dsr_q;

  // decode
  logic is_dbg;
  logic is_gpr;
  logic dbg_wr;

  //////////////////////////////
  // break FSM
  //////////////////////////////

  // host access only while fully stopped
  assign dbg_ack_o = dbg_strobe_i && (state_q == StallCore);

  always_comb
  begin
    state_d      = state_q;
    stall_core_o = 1'b0;
    flush_pipe_o = 1'b0;
    dbg_bp_o     = 1'b0;
    case (state_q)
      Idle:
      begin
        // host stall wins over a trap in the same cycle
        if (dbg_stall_i)
        begin
          flush_pipe_o = 1'b1;
          state_d      = DebugStall;
        end
        // single step breaks on every retire without the enable
        else if (trap_i && (dmr2_en_q || dmr1_st_q))
        begin
          state_d = Trap;
        end
      end
      Trap:
      begin
        // wait for the drain before signalling the host
        if (pipe_flushed_i)
        begin
          dbg_bp_o = 1'b1;
          state_d  = StallCore;
        end
      end
      DebugStall:
      begin
        flush_pipe_o = 1'b1;
        if (pipe_flushed_i)
          state_d = StallCore;
      end
      StallCore:
      begin
        stall_core_o = 1'b1;
        // run again once the host lets go
        if (!dbg_stall_i)
          state_d = Idle;
      end
      default:
      begin
        state_d = Idle;
      end
    endcase
  end

  //////////////////////////////
  // address decode
  //////////////////////////////

  // first level selects the debug register group
  assign is_dbg = (dbg_addr_i[15:11] == DBG_REG_PREFIX);
  // second level selects the GPR window
  assign is_gpr = !is_dbg && (dbg_addr_i[15:10] == GPR_PREFIX);

  // selects follow the ack so nothing moves outside a break
  assign gpr_sel_o = dbg_ack_o && is_gpr;
  assign spr_sel_o = dbg_ack_o && !is_dbg && !is_gpr;
  assign rf_we_o   = (gpr_sel_o || spr_sel_o) && dbg_we_i;

  // bank picks its own index bits
  assign rf_addr_o  = dbg_addr_i;
  assign rf_wdata_o = dbg_wdata_i;

  // debug register write this cycle
  assign dbg_wr = dbg_ack_o && is_dbg && dbg_we_i;

  //////////////////////////////
  // read data
  //////////////////////////////

  always_comb
  begin
    dbg_rdata_o = '0;
    if (dbg_ack_o && !dbg_we_i)
    begin
      if (is_dbg)
      begin
        case (dbg_addr_i[10:0])
          ADDR_DMR1:
            dbg_rdata_o[DMR1_ST_BIT] = dmr1_st_q;
          ADDR_DMR2:
          begin
            dbg_rdata_o[DMR2_EN_BIT]   = dmr2_en_q;
            dbg_rdata_o[DMR2_STAT_BIT] = dmr2_stat_q;
          end
          ADDR_DSR:
            dbg_rdata_o[DSR_LSB +: 2] = dsr_q;
          default:
            dbg_rdata_o = '0;
        endcase
      end
      else
      begin
        // GPR or SPR straight from the bank
        dbg_rdata_o = rf_rdata_i;
      end
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= Idle;
      dmr1_st_q   <= 1'b0;
      dmr2_en_q   <= 1'b0;
      dmr2_stat_q <= 1'b0;
      dsr_q       <= '0;
    end
    else
    begin
      state_q <= state_d;
      // break taken on trap
      if (dbg_bp_o)
        dmr2_stat_q <= 1'b1;
      if (dbg_wr)
      begin
        case (dbg_addr_i[10:0])
          ADDR_DMR1:
            dmr1_st_q <= dbg_wdata_i[DMR1_ST_BIT];
          ADDR_DMR2:
          begin
            dmr2_en_q   <= dbg_wdata_i[DMR2_EN_BIT];
            // any write acknowledges the break
            dmr2_stat_q <= 1'b0;
          end
          ADDR_DSR:
            dsr_q <= dbg_wdata_i[DSR_LSB +: 2];
          default:
            dsr_q <= dsr_q;
        endcase
      end
    end
  end

  // core side views
  assign st_en_o = dmr1_st_q;
  assign dsr_o   = dsr_q;

  //////////////////////////////
  // checks
  //////////////////////////////

  // host only touches registers with an empty pipeline
  a_ack_empty_pipe: assert property (
    @(posedge clk) disable iff (!rst_n)
    dbg_ack_o |-> pipe_flushed_i
  ) else $error("register access with instructions in flight");

endmodule

/* src/reg_bank.sv */
//////////////////////////////
// GPR array and SPR bank of the core model
// debug side reads are combinational, writes land at the next edge
// SPR_RETIRE_IDX counts retired instructions
//////////////////////////////

`timescale 1ns/1ps

module reg_bank
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // debug access
  input  logic      gpr_sel_i,
  input  logic      spr_sel_i,
  input  logic      we_i,
  input  dbg_addr_t addr_i,
  input  dbg_data_t wdata_i,
  output dbg_data_t rdata_o,

  // retire pulse from the pipeline
  input  logic      retire_i
);

  // storage
  dbg_data_t gpr_q [32];
  dbg_data_t spr_q [N_SPR];

  // index fields of the address
  gpr_idx_t gpr_idx;
  spr_idx_t spr_idx;

  // write strobes
  logic gpr_we;
  logic spr_we;
  logic cnt_wr;

  //////////////////////////////
  // decode
  //////////////////////////////

  // GPR from low 5 bits, SPR from low 3 bits
  assign gpr_idx = addr_i[4:0];
  assign spr_idx = addr_i[2:0];

  assign gpr_we = we_i && gpr_sel_i;
  assign spr_we = we_i && spr_sel_i;

  // host write to the retire counter
  assign cnt_wr = spr_we && (spr_idx == SPR_RETIRE_IDX);

  //////////////////////////////
  // GPR array
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
        gpr_q[i] <= '0;
    end
    else if (gpr_we)
    begin
      gpr_q[gpr_idx] <= wdata_i;
    end
  end

  //////////////////////////////
  // SPR bank
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < N_SPR; i++)
        spr_q[i] <= '0;
    end
    else
    begin
      // plain SPR write
      if (spr_we)
        spr_q[spr_idx] <= wdata_i;
      // counter step, host write to it has priority
      if (retire_i && !cnt_wr)
        spr_q[SPR_RETIRE_IDX] <= spr_q[SPR_RETIRE_IDX] + dbg_data_t'(1);
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb
  begin
    rdata_o = '0;
    if (gpr_sel_i)
      rdata_o = gpr_q[gpr_idx];
    else if (spr_sel_i)
      rdata_o = spr_q[spr_idx];
  end

  // decoder selects one target at most
  a_one_sel: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(gpr_sel_i && spr_sel_i)
  ) else $error("GPR and SPR selected together");

endmodule

/* src/pipe_tracker.sv */
//////////////////////////////
// occupancy model of the core pipeline
// one valid and one trap bit per stage, shifted every cycle
// issue enters stage 0 unless flush or stall holds it off,
// the last stage gives the retire pulse and the trap level
//////////////////////////////

`timescale 1ns/1ps

module pipe_tracker
  import dbg_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  // issue side of the core
  input  logic issue_i,
  input  logic issue_trap_i,

  // control from the debug unit
  input  logic flush_i,
  input  logic stall_i,
  input  logic st_en_i,

  // status back to the debug unit and the register bank
  output logic retire_o,
  output logic trap_o,
  output logic flushed_o
);

  // per-stage occupancy
  logic [PIPE_DEPTH-1:0] valid_q;
  logic [PIPE_DEPTH-1:0] trap_q;

  // new entry for stage 0
  logic issue_ok;

  //////////////////////////////
  // entry gating
  //////////////////////////////

  // no new work while draining or held
  assign issue_ok = issue_i && !flush_i && !stall_i;

  //////////////////////////////
  // stage shift
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= '0;
      trap_q  <= '0;
    end
    else
    begin
      // stage 0 takes the issue, the rest move one step on
      valid_q <= {valid_q[PIPE_DEPTH-2:0], issue_ok};
      // trap flag only travels with a valid entry
      trap_q  <= {trap_q[PIPE_DEPTH-2:0], issue_ok && issue_trap_i};
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  // last stage leaves the pipe this cycle
  assign retire_o = valid_q[PIPE_DEPTH-1];

  // trap instruction retiring, or any retire in single step
  assign trap_o = retire_o && (trap_q[PIPE_DEPTH-1] || st_en_i);

  // empty pipe
  assign flushed_o = ~|valid_q;

  //////////////////////////////
  // checks
  //////////////////////////////

  // an empty pipe cannot produce a retire in the next cycle
  a_no_retire_after_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(flushed_o) |-> !$rose(retire_o)
  ) else $error("retire after empty pipeline");

endmodule

/* src/dbg_pkg.sv */
//////////////////////////////
// shared constants and types for the debug subsystem
// address map of the debug port, register bit positions
// and the break state encoding
// import with dbg_pkg::* in the module header
//////////////////////////////

package dbg_pkg;

  //////////////////////////////
  // vector types
  //////////////////////////////

  // host address and data words
  typedef logic [15:0] dbg_addr_t;
  typedef logic [31:0] dbg_data_t;

  // register indices
  typedef logic [4:0]  gpr_idx_t;
  typedef logic [2:0]  spr_idx_t;

  // stop reason field of DSR
  typedef logic [1:0]  dsr_t;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // pipeline stages modelled by the tracker
  localparam int PIPE_DEPTH = 4;

  // special purpose register bank
  localparam int       N_SPR          = 8;
  localparam spr_idx_t SPR_RETIRE_IDX = 3'd0;

  //////////////////////////////
  // address map
  //////////////////////////////

  // upper 5 bits select the debug register group
  localparam logic [4:0]  DBG_REG_PREFIX = 5'b00110;
  // upper 6 bits select the GPRs
  localparam logic [5:0]  GPR_PREFIX     = 6'b000001;

  // offsets inside the debug register group
  localparam logic [10:0] ADDR_DMR1 = 11'd16;
  localparam logic [10:0] ADDR_DMR2 = 11'd17;
  localparam logic [10:0] ADDR_DSR  = 11'd20;

  // bit positions in the data word
  localparam int DMR1_ST_BIT   = 22;  // single-step enable
  localparam int DMR2_EN_BIT   = 12;  // trap break enable
  localparam int DMR2_STAT_BIT = 22;  // break taken status
  localparam int DSR_LSB       = 6;   // low bit of stop reason

  // break control states
  typedef enum logic [1:0] {
    Idle,
    Trap,
    DebugStall,
    StallCore
  } bp_state_e;

endpackage
